//--- logic/lamem_settings.svh
`ifndef LAMEM_SETTINGS_SVH
`define LAMEM_SETTINGS_SVH

// ------------------------------
// RAM geometry
// ------------------------------

// Depth in 32-bit words, kept a power of two so the word index wraps cleanly
`define LAMEM_RAM_WORDS 256

// ------------------------------
// Address map, byte 31:24
// ------------------------------

// Block RAM select
`define LAMEM_RAM_BASE 8'h00

// Timer select
`define LAMEM_TIMER_BASE 8'h10

`endif

//--- logic/lamem_pkg.sv
package lamem_pkg;

    // ------------------------------
    // Bus address
    // ------------------------------

    // Field view of the 32-bit look-ahead address
    typedef struct packed {
        // Peripheral select
        logic [7:0]  base;
        // Word index within the peripheral
        logic [21:0] word;
        // Byte lanes come from wstrb instead
        logic [1:0]  byte_off;
    } lamem_addr_f;

    // Same word seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        lamem_addr_f fields;
    } lamem_addr_u;

    // ------------------------------
    // Request and return words
    // ------------------------------

    // Look-ahead request, valid only in the cycle a strobe is high
    typedef struct packed {
        logic        rd;
        logic        wr;
        lamem_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } lamem_req_t;

    // Target answer, all zero when the target is not answering
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } lamem_ret_t;

    // ------------------------------
    // Timer register map
    // ------------------------------

    // Word indices under the timer base
    typedef enum logic [1:0] {
        COUNT   = 2'd0,
        COMPARE = 2'd1,
        CTRL    = 2'd2
    } lamem_tmr_reg_e;

endpackage

//--- logic/lamem_scrub_fsm.sv
`include "lamem_settings.svh"

module lamem_scrub_fsm (
    input  logic                                 clk,
    input  logic                                 rst_n,
    output logic                                 scrub_we,
    output logic [$clog2(`LAMEM_RAM_WORDS)-1:0]  scrub_addr,
    output logic                                 busy
);

    localparam int AW = $clog2(`LAMEM_RAM_WORDS);

    // Index of the final word in the sweep
    localparam logic [AW-1:0] LAST_WORD = AW'(`LAMEM_RAM_WORDS - 1);

    // ------------------------------
    // State encoding
    // ------------------------------

    // Sweeping, one word per cycle
    localparam logic [1:0] CLEAR = 2'd0;
    // Guard cycle after the last word, bus still closed
    localparam logic [1:0] LAST  = 2'd1;
    // Parked until the next reset
    localparam logic [1:0] IDLE  = 2'd2;

    logic [1:0]    state;
    logic [1:0]    state_nxt;
    logic [AW-1:0] addr_q;

    // ------------------------------
    // Next state
    // ------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            CLEAR: begin
                // Leave once the last word has been written
                if (addr_q == LAST_WORD) begin
                    state_nxt = LAST;
                end
            end
            LAST: begin
                state_nxt = IDLE;
            end
            IDLE: begin
                state_nxt = IDLE;
            end
            default: begin
                // Unused code, restart the sweep
                state_nxt = CLEAR;
            end
        endcase
    end

    // State and sweep counter, both restart on every reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= CLEAR;
            addr_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == CLEAR) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    // Outputs decoded straight from state
    assign scrub_we   = (state == CLEAR);
    assign scrub_addr = addr_q;
    assign busy       = (state != IDLE);

endmodule

//--- logic/lamem_block_ram.sv
`include "lamem_settings.svh"

module lamem_block_ram (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  lamem_pkg::lamem_req_t                req,
    input  logic                                 scrub_we,
    input  logic [$clog2(`LAMEM_RAM_WORDS)-1:0]  scrub_addr,
    input  logic                                 busy,
    output lamem_pkg::lamem_ret_t                ret
);

    localparam int AW = $clog2(`LAMEM_RAM_WORDS);

    // ------------------------------
    // Storage and decode
    // ------------------------------

    // Word array, contents set by the scrub sweep after reset
    logic [31:0] mem [0:`LAMEM_RAM_WORDS-1];

    // Request aimed here, and the bus is open
    logic hit;

    // Word index, upper bits dropped so it wraps modulo the depth
    logic [AW-1:0] idx;

    // Word contents before this edge's write
    logic [31:0] old_word;

    // Base byte compare, strobes, and no scrub in progress
    assign hit = (req.addr.fields.base == `LAMEM_RAM_BASE)
              && (req.rd || req.wr)
              && !busy;

    assign idx = req.addr.fields.word[AW-1:0];

    assign old_word = mem[idx];

    // ------------------------------
    // Write port
    // ------------------------------

    always_ff @(posedge clk) begin
        if (scrub_we) begin
            // Scrub clears one whole word per cycle
            mem[scrub_addr] <= '0;
        end else if (rst_n && hit && req.wr) begin
            // Byte lanes follow wstrb
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Return word
    // ------------------------------

    // One-cycle ready pulse per accepted request
    // Read data is the old word, so a read with a write sees pre-write contents
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret <= '0;
        end else begin
            ret.ready <= hit;
            // Write alone returns zero data
            if (hit && req.rd) begin
                ret.rdata <= old_word;
            end else begin
                ret.rdata <= '0;
            end
        end
    end

endmodule

//--- logic/lamem_timer.sv
`include "lamem_settings.svh"

module lamem_timer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lamem_pkg::lamem_req_t req,
    input  logic                  busy,
    output lamem_pkg::lamem_ret_t ret,
    output logic                  irq
);

    import lamem_pkg::*;

    // ------------------------------
    // Registers and decode
    // ------------------------------

    logic [31:0] count;
    logic [31:0] compare;
    // CTRL bit 0
    logic        en;
    // CTRL bit 1, sticky until a CTRL write
    logic        match;

    logic        hit;
    logic        wr_hit;
    logic        sel_count;
    logic        sel_compare;
    logic        sel_ctrl;
    logic [31:0] rd_word;
    logic [31:0] count_nxt;
    logic [31:0] compare_nxt;

    // Timer base, a strobe, and the scrub done
    assign hit = (req.addr.fields.base == `LAMEM_TIMER_BASE)
              && (req.rd || req.wr)
              && !busy;
    assign wr_hit = hit && req.wr;

    // Full word index compare, so aliases above CTRL are not decoded
    assign sel_count   = (req.addr.fields.word == 22'(COUNT));
    assign sel_compare = (req.addr.fields.word == 22'(COMPARE));
    assign sel_ctrl    = (req.addr.fields.word == 22'(CTRL));

    // Read mux, unmapped words read zero
    always_comb begin
        rd_word = '0;
        if (sel_count) begin
            rd_word = count;
        end else if (sel_compare) begin
            rd_word = compare;
        end else if (sel_ctrl) begin
            rd_word = {30'd0, match, en};
        end
    end

    // ------------------------------
    // Counter and compare update
    // ------------------------------

    // Strobed bytes of a write override the incremented count
    always_comb begin
        count_nxt   = count + {31'd0, en};
        compare_nxt = compare;
        for (int b = 0; b < 4; b++) begin
            if (wr_hit && req.wstrb[b]) begin
                if (sel_count) begin
                    count_nxt[8*b +: 8] = req.wdata[8*b +: 8];
                end
                if (sel_compare) begin
                    compare_nxt[8*b +: 8] = req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            compare <= '0;
            en      <= 1'b0;
            match   <= 1'b0;
        end else begin
            count   <= count_nxt;
            compare <= compare_nxt;
            if (wr_hit && sel_ctrl) begin
                // CTRL write wins over a match in the same cycle
                en    <= req.wdata[0];
                match <= 1'b0;
            end else if (en && (count == compare)) begin
                match <= 1'b1;
            end
        end
    end

    // Level interrupt straight from the sticky flag
    assign irq = match;

    // ------------------------------
    // Return word
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret <= '0;
        end else begin
            ret.ready <= hit;
            ret.rdata <= (hit && req.rd) ? rd_word : '0;
        end
    end

endmodule

//--- logic/lamem_top.sv
`include "lamem_settings.svh"

module lamem_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lamem_pkg::lamem_req_t req,
    output lamem_pkg::lamem_ret_t ret,
    output logic                  irq,
    output logic                  scrub_busy
);

    import lamem_pkg::*;

    // ------------------------------
    // Internal wiring
    // ------------------------------

    // Scrub FSM to RAM
    logic                                scrub_we;
    logic [$clog2(`LAMEM_RAM_WORDS)-1:0] scrub_addr;
    // Bus closed while high
    logic                                busy;

    // Per-target returns, zero when idle
    lamem_ret_t ram_ret;
    lamem_ret_t tmr_ret;

    // ------------------------------
    // Blocks
    // ------------------------------

    lamem_scrub_fsm u_scrub (
        .clk        (clk),
        .rst_n      (rst_n),
        .scrub_we   (scrub_we),
        .scrub_addr (scrub_addr),
        .busy       (busy)
    );

    // Each target decodes its own base byte
    lamem_block_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .scrub_we   (scrub_we),
        .scrub_addr (scrub_addr),
        .busy       (busy),
        .ret        (ram_ret)
    );

    lamem_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .busy  (busy),
        .ret   (tmr_ret),
        .irq   (irq)
    );

    // Only one target answers per cycle, so OR is the merge
    assign ret = lamem_ret_t'(ram_ret | tmr_ret);

    assign scrub_busy = busy;

endmodule

//--- dv/lamem_asserts.sv
`include "lamem_settings.svh"

module lamem_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input lamem_pkg::lamem_req_t req,
    input lamem_pkg::lamem_ret_t ret,
    input logic                  irq,
    input logic                  scrub_busy
);

    import lamem_pkg::*;

    // Number of failed properties so far
    int fail_count;

    // Any strobe on the bus
    logic strobe;
    // Accepted write to the timer CTRL word
    logic ctrl_wr;

    initial fail_count = 0;

    assign strobe  = req.rd || req.wr;
    assign ctrl_wr = req.wr
                  && (req.addr.fields.base == `LAMEM_TIMER_BASE)
                  && (req.addr.fields.word == 22'(CTRL))
                  && !scrub_busy;

    // ------------------------------
    // Bus properties
    // ------------------------------

    // Bus stays silent during the scrub sweep
    a_quiet_scrub: assert property (@(posedge clk) disable iff (!rst_n)
        scrub_busy |-> (ret == '0))
    else begin
        $error("ret is not zero while scrub_busy is high");
        fail_count = fail_count + 1;
    end

    // No strobe, no ready on the following sample
    a_no_spurious_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !strobe |=> !ret.ready)
    else begin
        $error("ready rose without a request strobe");
        fail_count = fail_count + 1;
    end

    // CTRL write drops the match flag, so irq is low next cycle
    a_ctrl_clears_irq: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_wr |=> !irq)
    else begin
        $error("irq high in the cycle after a CTRL write");
        fail_count = fail_count + 1;
    end

endmodule

bind lamem_top lamem_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ret        (ret),
    .irq        (irq),
    .scrub_busy (scrub_busy)
);

//--- dv/lamem_tb.sv
`include "lamem_settings.svh"

module lamem_tb;

    import lamem_pkg::*;

    localparam int WORDS       = `LAMEM_RAM_WORDS;
    // Bounds for the polling loops
    localparam int SCRUB_LIMIT = `LAMEM_RAM_WORDS + 64;
    localparam int IRQ_LIMIT   = 64;

    logic       clk;
    logic       rst_n;
    lamem_req_t req;
    lamem_ret_t ret;
    logic       irq;
    logic       scrub_busy;

    // ------------------------------
    // Reference model state
    // ------------------------------

    logic [31:0] mem_model [0:WORDS-1];
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_en;
    logic        m_match;
    // Low from reset until scrub_busy is seen falling
    logic        bus_open;

    lamem_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ret        (ret),
        .irq        (irq),
        .scrub_busy (scrub_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // Byte lanes of wdata replace the old word where strobed
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] wstrb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic lamem_req_t make_req(input logic [7:0] base, input logic [21:0] word,
                                            input logic rd, input logic wr,
                                            input logic [31:0] wdata, input logic [3:0] wstrb);
        lamem_req_t r;
        r.rd                   = rd;
        r.wr                   = wr;
        r.addr.fields.base     = base;
        r.addr.fields.word     = word;
        r.addr.fields.byte_off = 2'($urandom_range(0, 3));
        r.wdata                = wdata;
        r.wstrb                = wstrb;
        return r;
    endfunction

    // Random read, write or read with write, with random data and lanes
    function automatic lamem_req_t random_op(input logic [7:0] base, input logic [21:0] word);
        int kind;
        kind = $urandom_range(0, 2);
        return make_req(base, word, kind != 1, kind != 0, $urandom, 4'($urandom));
    endfunction

    task automatic model_reset();
        for (int i = 0; i < WORDS; i++) begin
            mem_model[i] = '0;
        end
        m_count   = '0;
        m_compare = '0;
        m_en      = 1'b0;
        m_match   = 1'b0;
    endtask

    // Advances the model by one rising edge and gives the expected answer to r
    task automatic model_step(input lamem_req_t r, output lamem_ret_t exp);
        logic        strobe;
        logic [21:0] word;
        int          idx;
        logic [31:0] next_count;
        logic        ctrl_wr;
        strobe     = r.rd || r.wr;
        word       = r.addr.fields.word;
        idx        = int'(word) % WORDS;
        exp        = '0;
        ctrl_wr    = 1'b0;
        next_count = m_count + (m_en ? 32'd1 : 32'd0);
        // RAM read sees the word before this edge's write
        if (bus_open && strobe && r.addr.fields.base == `LAMEM_RAM_BASE) begin
            exp.ready = 1'b1;
            if (r.rd) begin
                exp.rdata = mem_model[idx];
            end
            if (r.wr) begin
                mem_model[idx] = merge_bytes(mem_model[idx], r.wdata, r.wstrb);
            end
        end
        if (bus_open && strobe && r.addr.fields.base == `LAMEM_TIMER_BASE) begin
            exp.ready = 1'b1;
            if (r.rd && word == 22'(COUNT)) begin
                exp.rdata = m_count;
            end else if (r.rd && word == 22'(COMPARE)) begin
                exp.rdata = m_compare;
            end else if (r.rd && word == 22'(CTRL)) begin
                exp.rdata = {30'd0, m_match, m_en};
            end
            if (r.wr && word == 22'(COUNT)) begin
                next_count = merge_bytes(next_count, r.wdata, r.wstrb);
            end
            if (r.wr && word == 22'(COMPARE)) begin
                m_compare = merge_bytes(m_compare, r.wdata, r.wstrb);
            end
            ctrl_wr = r.wr && (word == 22'(CTRL));
        end
        // Match looks at count and compare before the edge
        if (ctrl_wr) begin
            m_match = 1'b0;
            m_en    = r.wdata[0];
        end else if (m_en && (m_count == m_compare)) begin
            m_match = 1'b1;
        end
        m_count = next_count;
    endtask

    // Drive on the falling edge and check one edge later
    task automatic bus_cycle(input lamem_req_t r);
        lamem_ret_t exp;
        req = r;
        model_step(r, exp);
        @(posedge clk);
        @(negedge clk);
        check_value("ret.ready", 32'(exp.ready), 32'(ret.ready));
        check_value("ret.rdata", exp.rdata, ret.rdata);
        check_value("irq", 32'(m_match), 32'(irq));
        if (bus_open) begin
            check_value("scrub_busy", 32'd0, 32'(scrub_busy));
        end
        if (u_dut.u_asserts.fail_count != 0) begin
            $display("A bound assertion on lamem_top failed at t=%0t", $time);
            stop_on_failure();
        end
    endtask

    // ------------------------------
    // Sequences
    // ------------------------------

    task automatic apply_reset();
        rst_n    = 1'b0;
        req      = '0;
        bus_open = 1'b0;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ret during reset", 32'd0, 32'(ret.ready) | ret.rdata);
            check_value("irq during reset", 32'd0, 32'(irq));
            check_value("scrub_busy during reset", 32'd1, 32'(scrub_busy));
        end
        rst_n = 1'b1;
        model_reset();
    endtask

    // Requests during the sweep must stay unanswered
    task automatic wait_scrub_done();
        int         edges;
        logic [7:0] base;
        edges = 0;
        while (scrub_busy) begin
            if (edges >= SCRUB_LIMIT) begin
                $display("Timeout: scrub_busy still high %0d cycles after reset", edges);
                stop_on_failure();
            end
            base = ($urandom_range(0, 1) == 0) ? `LAMEM_RAM_BASE : `LAMEM_TIMER_BASE;
            bus_cycle(random_op(base, 22'($urandom_range(0, 3))));
            edges++;
        end
        check_value("scrub length in cycles", 32'(WORDS + 1), 32'(edges));
        bus_open = 1'b1;
    endtask

    task automatic read_all_ram();
        for (int i = 0; i < WORDS; i++) begin
            bus_cycle(make_req(`LAMEM_RAM_BASE, 22'(i), 1'b1, 1'b0, 32'd0, 4'd0));
        end
    endtask

    task automatic timer_write(input lamem_tmr_reg_e sel, input logic [31:0] data);
        bus_cycle(make_req(`LAMEM_TIMER_BASE, 22'(sel), 1'b0, 1'b1, data, 4'hf));
    endtask

    task automatic timer_read(input lamem_tmr_reg_e sel);
        bus_cycle(make_req(`LAMEM_TIMER_BASE, 22'(sel), 1'b1, 1'b0, 32'd0, 4'd0));
    endtask

    task automatic idle_cycle();
        bus_cycle(make_req(`LAMEM_RAM_BASE, 22'd0, 1'b0, 1'b0, 32'd0, 4'd0));
    endtask

    // Word indices above the depth exercise the wrap
    task automatic ram_traffic(input int n);
        for (int k = 0; k < n; k++) begin
            bus_cycle(random_op(`LAMEM_RAM_BASE, 22'($urandom_range(0, 4 * WORDS - 1))));
        end
    endtask

    task automatic timer_counting();
        logic [31:0] start;
        int          idle_n;
        repeat (4) begin
            start  = $urandom;
            idle_n = $urandom_range(1, 20);
            timer_write(COUNT, start);
            timer_write(CTRL, 32'd1);
            repeat (idle_n) idle_cycle();
            timer_read(COUNT);
            check_value("COUNT after idle", start + 32'(idle_n), ret.rdata);
            timer_write(CTRL, 32'd0);
        end
    endtask

    task automatic timer_irq();
        logic [31:0] start;
        int          ahead;
        int          cycles;
        repeat (2) begin
            start = $urandom;
            ahead = $urandom_range(2, 8);
            timer_write(CTRL, 32'd0);
            timer_write(COUNT, start);
            timer_write(COMPARE, start + 32'(ahead));
            timer_write(CTRL, 32'd1);
            cycles = 0;
            while (!irq) begin
                if (cycles >= IRQ_LIMIT) begin
                    $display("Timeout: irq did not rise within %0d cycles", IRQ_LIMIT);
                    stop_on_failure();
                end
                idle_cycle();
                cycles++;
            end
            // Match seen one edge after count reaches compare
            check_value("cycles until irq", 32'(ahead + 1), 32'(cycles));
            timer_read(CTRL);
            check_value("CTRL match bit", 32'd1, 32'(ret.rdata[1]));
            timer_write(CTRL, 32'd0);
            check_value("irq after CTRL write", 32'd0, 32'(irq));
        end
    endtask

    task automatic unmapped_traffic();
        logic [7:0] base;
        repeat (64) begin
            base = 8'($urandom);
            if (base == `LAMEM_RAM_BASE || base == `LAMEM_TIMER_BASE) begin
                base = base ^ 8'h80;
            end
            bus_cycle(random_op(base, 22'($urandom)));
            check_value("ready on unmapped base", 32'd0, 32'(ret.ready));
        end
        // State reads back unchanged and word 3 reads zero with ready
        read_all_ram();
        timer_read(COUNT);
        timer_read(COMPARE);
        timer_read(CTRL);
        bus_cycle(make_req(`LAMEM_TIMER_BASE, 22'd3, 1'b1, 1'b0, 32'd0, 4'd0));
    endtask

    initial begin
        rst_n     = 1'b0;
        req       = '0;
        bus_open  = 1'b0;
        void'($urandom(32'ha153));
        model_reset();

        apply_reset();
        wait_scrub_done();
        read_all_ram();
        ram_traffic(600);
        timer_counting();
        timer_irq();
        unmapped_traffic();

        // Second reset must wipe the words written above
        apply_reset();
        wait_scrub_done();
        read_all_ram();
        timer_read(COUNT);
        timer_read(CTRL);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- lamem.f
+incdir+logic
logic/lamem_pkg.sv
logic/lamem_scrub_fsm.sv
logic/lamem_block_ram.sv
logic/lamem_timer.sv
logic/lamem_top.sv
dv/lamem_asserts.sv
dv/lamem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the lamem testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert \
    --top-module lamem_tb \
    -Mdir "$OBJ" \
    -f lamem.f > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

# Error limit lets the testbench see a failed assertion and report it
"./$OBJ/Vlamem_tb" +verilator+error+limit+100 > "$SIM_LOG" 2>&1 \
    || echo "Simulator returned a nonzero status" >> "$SIM_LOG"

cat "$SIM_LOG"

grep -q "Simulation finished: FAIL" "$SIM_LOG" && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation finished: PASS" "$SIM_LOG" || { echo "Result: no pass line, FAIL"; exit 1; }
echo "Result: PASS"
exit 0
